// ==== sim.f ====
tpu_pkg.sv
tpu_cmd_decoder.sv
tpu_operand_buffer.sv
tpu_controller.sv
tpu_mac_cell.sv
tpu_systolic_array.sv
tpu_output_unit.sv
tt_um_tpu.sv
tb_tpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tpu
FLAGS     ?=
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator from sim.f and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary --top-module $(TOP) -f sim.f -Mdir $(OBJ_DIR) $(FLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q ">>> PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_tpu.sv ====
`timescale 1ns/100ps

module tb_tpu;

    localparam int CLK_PERIOD  = 40;
    localparam int N_FIXED     = 8;
    localparam int N_RAND      = 8;
    localparam int N_ROWS      = N_FIXED + N_RAND;
    localparam int DONE_LIMIT  = 20;
    localparam int WATCHDOG_NS = (N_ROWS * 40 + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'd83528;
    // how a row is applied
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_HELD_W  = 1;
    localparam int MODE_BUSY_IN = 2;

    logic       clk;
    logic       reset;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    // stimulus and expected bytes, one row per run
    logic        [7:0] tab_ins   [N_ROWS];
    logic signed [7:0] tab_w     [N_ROWS][4];
    logic signed [7:0] tab_x     [N_ROWS][4];
    logic              tab_chain [N_ROWS];
    int                tab_mode  [N_ROWS];
    logic        [7:0] tab_exp   [N_ROWS][4];

    int          errors;
    int          checks;
    logic [31:0] rng;

    tt_um_tpu u_dut (
        .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
        .uio_oe(uio_oe), .ena(ena), .clk(clk), .reset(reset)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // shift, relu and clamp of one raw sum, per the instruction byte
    function automatic logic [7:0] result_byte(input int y, input logic [7:0] ins);
        int s;
        s = y >>> ins[tpu_pkg::INS_SHIFT_LSB +: tpu_pkg::INS_SHIFT_W];
        if (ins[tpu_pkg::INS_RELU_BIT] && s < 0) begin
            s = 0;
        end
        if (s > 127) begin
            return 8'h7F;
        end else if (s < -128) begin
            return 8'h80;
        end
        return s[7:0];
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    // w and x packed as four bytes, entry 0 in the top byte
    task automatic set_row(input int i, input logic [7:0] ins, input logic [31:0] w,
                           input logic [31:0] x, input logic chain, input int mode);
        tab_ins[i]   = ins;
        tab_chain[i] = chain;
        tab_mode[i]  = mode;
        for (int j = 0; j < 4; j++) begin
            tab_w[i][j] = w[31 - 8 * j -: 8];
            tab_x[i][j] = x[31 - 8 * j -: 8];
        end
    endtask

    task automatic build_table();
        int y;
        int prev [4];
        set_row(0, 8'h00, {8'sd1, 8'sd2, 8'sd3, 8'sd4}, {8'sd1, -8'sd1, 8'sd2, 8'sd3},
                1'b0, MODE_PLAIN);
        // big operands, clamps at shift 4, plain division at shift 8
        set_row(1, 8'h04, {8'sd100, -8'sd100, 8'sd127, 8'h80},
                {8'sd127, 8'h80, 8'sd90, 8'sd60}, 1'b0, MODE_PLAIN);
        set_row(2, 8'h08, {8'sd100, -8'sd100, 8'sd127, 8'h80},
                {8'sd127, 8'h80, 8'sd90, 8'sd60}, 1'b0, MODE_PLAIN);
        set_row(3, 8'h40, {8'sd5, -8'sd3, 8'sd2, 8'sd7}, {8'sd4, -8'sd6, -8'sd2, 8'sd3},
                1'b0, MODE_PLAIN);
        // base product, then one added on top with shift 1
        set_row(4, 8'h00, {8'sd10, 8'sd20, -8'sd30, 8'sd40}, {8'sd3, 8'sd4, 8'sd5, -8'sd6},
                1'b0, MODE_PLAIN);
        set_row(5, 8'h81, {8'sd7, -8'sd8, 8'sd9, 8'sd10}, {-8'sd5, 8'sd6, 8'sd7, 8'sd8},
                1'b1, MODE_PLAIN);
        set_row(6, 8'h00, {8'sd2, -8'sd3, 8'sd4, 8'sd5}, {8'sd6, 8'sd7, -8'sd8, 8'sd9},
                1'b0, MODE_HELD_W);
        set_row(7, 8'h02, {-8'sd50, 8'sd60, 8'sd70, -8'sd80},
                {8'sd11, -8'sd12, 8'sd13, 8'sd14}, 1'b0, MODE_BUSY_IN);
        // random rows, acc bit cleared and shift kept below 8
        for (int i = N_FIXED; i < N_ROWS; i++) begin
            rng = xorshift32(rng);
            tab_ins[i] = rng[7:0] & 8'h47;
            rng = xorshift32(rng);
            set_row(i, tab_ins[i], rng, xorshift32(rng), 1'b0, MODE_PLAIN);
            rng = xorshift32(rng);
        end
        // y[r][c] = sum over k of x[r][k] * w[k][c]
        for (int i = 0; i < N_ROWS; i++) begin
            for (int e = 0; e < 4; e++) begin
                y = 0;
                for (int k = 0; k < 2; k++) begin
                    y = y + int'(tab_x[i][(e / 2) * 2 + k]) * int'(tab_w[i][k * 2 + e % 2]);
                end
                if (tab_chain[i]) begin
                    y = y + prev[e];
                end
                prev[e] = y;
                tab_exp[i][e] = result_byte(y, tab_ins[i]);
            end
        end
    endtask

    // drive on a falling edge, hold, then one NOP cycle
    task automatic send_cmd(input logic [2:0] code, input logic [7:0] din, input int hold);
        uio_in = {code, 5'b0};
        ui_in  = din;
        repeat (hold) @(negedge clk);
        uio_in = {tpu_pkg::NOP, 5'b0};
        ui_in  = 8'h00;
        @(negedge clk);
    endtask

    task automatic run_row(input int i);
        int    wait_cnt;
        string name;
        send_cmd(tpu_pkg::LOAD_INS, tab_ins[i], 1);
        for (int j = 0; j < 4; j++) begin
            // held code must still give a single write
            send_cmd(tpu_pkg::LOAD_W, tab_w[i][j], (tab_mode[i] == MODE_HELD_W && j == 0) ? 4 : 1);
        end
        for (int j = 0; j < 4; j++) begin
            send_cmd(tpu_pkg::LOAD_IN, tab_x[i][j], 1);
        end
        send_cmd(tpu_pkg::START, 8'h00, 1);
        if (tab_mode[i] == MODE_BUSY_IN) begin
            check_val($sformatf("busy row %0d", i), int'(uio_out[1]), 1);
            // should be dropped
            send_cmd(tpu_pkg::LOAD_IN, 8'h7E, 1);
        end
        wait_cnt = 0;
        while (!uio_out[0] && wait_cnt < DONE_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!uio_out[0]) begin
            errors++;
            $display("row %0d: done was not raised within %0d cycles", i, DONE_LIMIT);
        end
        // read order y00 y01 y10 y11
        for (int j = 0; j < 4; j++) begin
            send_cmd(tpu_pkg::READ, 8'h00, 1);
            name = $sformatf("uo_out row %0d y%0d%0d", i, j / 2, j % 2);
            check_val(name, int'(uo_out), int'(tab_exp[i][j]));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk    = 1'b0;
        reset  = 1'b1;
        ena    = 1'b1;
        ui_in  = 8'h00;
        uio_in = 8'h00;
        errors = 0;
        checks = 0;
        rng    = SEED;
        build_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_val("uo_out after reset", int'(uo_out), 0);
        check_val("done after reset", int'(uio_out[0]), 0);
        check_val("busy after reset", int'(uio_out[1]), 0);
        check_val("uio_out[7:2] after reset", int'(uio_out[7:2]), 0);
        check_val("uio_oe", int'(uio_oe), 8'h1F);
        // decoder arms on this NOP
        @(negedge clk);
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tt_um_tpu.sv ====
`timescale 1ns/100ps

module tt_um_tpu #(
    parameter int ACC_W = 18
) (
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    input  logic [7:0] uio_in,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    // powered-on flag, not needed here
    input  logic       ena,
    input  logic       clk,
    input  logic       reset
);

    // decoder strobes and byte
    logic                              fetch_w;
    logic                              fetch_inp;
    logic                              fetch_ins;
    logic                              start;
    logic                              read;
    logic        [tpu_pkg::DATA_W-1:0] data;
    // operands
    logic signed [tpu_pkg::DATA_W-1:0] w00, w01, w10, w11;
    logic signed [tpu_pkg::DATA_W-1:0] x00, x01, x10, x11;
    // controller
    logic                              ins_acc;
    logic                              ins_relu;
    logic [tpu_pkg::INS_SHIFT_W-1:0]   ins_shift;
    logic                              busy;
    logic                              done;
    logic                              clear_acc;
    logic                              capture;
    logic                              load_en;
    logic signed [tpu_pkg::DATA_W-1:0] row0_in;
    logic signed [tpu_pkg::DATA_W-1:0] row1_in;
    // array sums at capture
    logic signed [ACC_W-1:0]           sum0, sum1, sum0_r1, sum1_r1;

    // command fetch, command on uio_in[7:5]
    tpu_cmd_decoder u_decoder (
        .clk(clk), .reset(reset), .cmd(uio_in[7:5]), .din(ui_in),
        .fetch_w(fetch_w), .fetch_inp(fetch_inp), .fetch_ins(fetch_ins),
        .start(start), .read(read), .data(data)
    );

    // loads are dropped while busy
    tpu_operand_buffer u_weights (
        .clk(clk), .reset(reset), .wr(fetch_w && load_en), .data(data),
        .e0(w00), .e1(w01), .e2(w10), .e3(w11)
    );
    tpu_operand_buffer u_inputs (
        .clk(clk), .reset(reset), .wr(fetch_inp && load_en), .data(data),
        .e0(x00), .e1(x01), .e2(x10), .e3(x11)
    );

    tpu_controller u_ctrl (
        .clk(clk), .reset(reset), .fetch_ins(fetch_ins), .start(start), .data(data),
        .x0_k0(x00), .x0_k1(x01), .x1_k0(x10), .x1_k1(x11),
        .ins_acc(ins_acc), .ins_relu(ins_relu), .ins_shift(ins_shift),
        .busy(busy), .done(done), .clear_acc(clear_acc), .capture(capture),
        .row0_in(row0_in), .row1_in(row1_in), .load_en(load_en)
    );

    // weights track the buffer whenever idle
    tpu_systolic_array #(.ACC_W(ACC_W)) u_array (
        .clk(clk), .reset(reset), .load_w(load_en), .clear(clear_acc),
        .w00(w00), .w01(w01), .w10(w10), .w11(w11), .a0(row0_in), .a1(row1_in),
        .sum0(sum0), .sum1(sum1), .sum0_r1(sum0_r1), .sum1_r1(sum1_r1)
    );

    // reads are served even during a run
    tpu_output_unit #(.ACC_W(ACC_W)) u_out (
        .clk(clk), .reset(reset), .capture(capture), .accumulate(ins_acc),
        .relu(ins_relu), .shift(ins_shift), .read(read),
        .sum0(sum0), .sum1(sum1), .sum0_r1(sum0_r1), .sum1_r1(sum1_r1),
        .dout(uo_out)
    );

    // status on the low bidir pins, upper three stay inputs
    assign uio_out = {6'b0, busy, done};
    assign uio_oe  = 8'h1F;

endmodule

// ==== tpu_output_unit.sv ====
`timescale 1ns/100ps

module tpu_output_unit #(
    parameter int ACC_W = 18
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    capture,
    input  logic                    accumulate,
    input  logic                    relu,
    input  logic [3:0]              shift,
    input  logic                    read,
    input  logic signed [ACC_W-1:0] sum0,
    input  logic signed [ACC_W-1:0] sum1,
    input  logic signed [ACC_W-1:0] sum0_r1,
    input  logic signed [ACC_W-1:0] sum1_r1,
    output logic [7:0]              dout
);

    // signed byte limits
    localparam logic signed [ACC_W-1:0] SAT_HI = 127;
    localparam logic signed [ACC_W-1:0] SAT_LO = -128;

    // held results, y00 y01 y10 y11
    logic signed [ACC_W-1:0] res [4];
    logic signed [ACC_W-1:0] cap [4];
    logic        [1:0]       rd_ptr;

    assign cap[0] = sum0;
    assign cap[1] = sum1;
    assign cap[2] = sum0_r1;
    assign cap[3] = sum1_r1;

    // shift, optional relu, clamp to a signed byte
    function automatic logic [7:0] post_byte(
        input logic signed [ACC_W-1:0] v,
        input logic                    use_relu,
        input logic [3:0]              sh
    );
        logic signed [ACC_W-1:0] s;
        s = v >>> sh;
        if (use_relu && s < 0) begin
            s = '0;
        end
        if (s > SAT_HI) begin
            post_byte = 8'h7F;
        end else if (s < SAT_LO) begin
            post_byte = 8'h80;
        end else begin
            post_byte = s[7:0];
        end
    endfunction

    // replace or add onto the previous run
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int i = 0; i < 4; i++) begin
                res[i] <= accumulate ? res[i] + cap[i] : cap[i];
            end
        end
    end

    // read-out, pointer restarts at every capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            dout   <= '0;
        end else if (capture) begin
            rd_ptr <= '0;
        end else if (read) begin
            dout   <= post_byte(res[rd_ptr], relu, shift);
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== tpu_systolic_array.sv ====
`timescale 1ns/100ps

module tpu_systolic_array #(
    parameter int ACC_W = 18
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load_w,
    input  logic                              clear,
    input  logic signed [tpu_pkg::DATA_W-1:0] w00,
    input  logic signed [tpu_pkg::DATA_W-1:0] w01,
    input  logic signed [tpu_pkg::DATA_W-1:0] w10,
    input  logic signed [tpu_pkg::DATA_W-1:0] w11,
    input  logic signed [tpu_pkg::DATA_W-1:0] a0,
    input  logic signed [tpu_pkg::DATA_W-1:0] a1,
    output logic signed [ACC_W-1:0]           sum0,
    output logic signed [ACC_W-1:0]           sum1,
    output logic signed [ACC_W-1:0]           sum0_r1,
    output logic signed [ACC_W-1:0]           sum1_r1
);

    // inputs between columns
    logic signed [tpu_pkg::DATA_W-1:0] a0_c1;
    logic signed [tpu_pkg::DATA_W-1:0] a1_c1;
    // partial sums between rows and at the bottom
    logic signed [ACC_W-1:0] p00;
    logic signed [ACC_W-1:0] p01;
    logic signed [ACC_W-1:0] p10;
    logic signed [ACC_W-1:0] p11;
    // output deskew
    logic signed [ACC_W-1:0] col0_d;
    logic signed [ACC_W-1:0] col0_dd;
    logic signed [ACC_W-1:0] col1_d;

    // top row, k = 0
    tpu_mac_cell #(.ACC_W(ACC_W)) u_c00 (
        .clk(clk), .reset(reset), .load_w(load_w), .w_in(w00), .a_in(a0),
        .psum_in('0), .clear(clear), .a_out(a0_c1), .psum_out(p00)
    );
    tpu_mac_cell #(.ACC_W(ACC_W)) u_c01 (
        .clk(clk), .reset(reset), .load_w(load_w), .w_in(w01), .a_in(a0_c1),
        .psum_in('0), .clear(clear), .a_out(), .psum_out(p01)
    );

    // bottom row, k = 1
    tpu_mac_cell #(.ACC_W(ACC_W)) u_c10 (
        .clk(clk), .reset(reset), .load_w(load_w), .w_in(w10), .a_in(a1),
        .psum_in(p00), .clear(clear), .a_out(a1_c1), .psum_out(p10)
    );
    tpu_mac_cell #(.ACC_W(ACC_W)) u_c11 (
        .clk(clk), .reset(reset), .load_w(load_w), .w_in(w11), .a_in(a1_c1),
        .psum_in(p01), .clear(clear), .a_out(), .psum_out(p11)
    );

    // column 0 leads column 1 by a cycle, so it gets one extra stage
    always_ff @(posedge clk) begin
        col0_d  <= p10;
        col0_dd <= col0_d;
        col1_d  <= p11;
    end

    // at capture: row 0 is one stage back, row 1 is current
    assign sum0    = col0_dd;
    assign sum1    = col1_d;
    assign sum0_r1 = col0_d;
    assign sum1_r1 = p11;

endmodule

// ==== tpu_mac_cell.sv ====
`timescale 1ns/100ps

module tpu_mac_cell #(
    parameter int ACC_W = 18
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load_w,
    input  logic signed [tpu_pkg::DATA_W-1:0] w_in,
    input  logic signed [tpu_pkg::DATA_W-1:0] a_in,
    input  logic signed [ACC_W-1:0]           psum_in,
    input  logic                              clear,
    output logic signed [tpu_pkg::DATA_W-1:0] a_out,
    output logic signed [ACC_W-1:0]           psum_out
);

    logic signed [tpu_pkg::DATA_W-1:0] weight;

    // stationary weight, refreshed while idle
    always_ff @(posedge clk) begin
        if (load_w) begin
            weight <= w_in;
        end
    end

    // input moves right, partial sum moves down
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_out    <= '0;
            psum_out <= '0;
        end else begin
            a_out <= a_in;
            if (clear) begin
                psum_out <= '0;
            end else begin
                // full signed product, sign extended to ACC_W
                psum_out <= psum_in + weight * a_in;
            end
        end
    end

endmodule

// ==== tpu_controller.sv ====
`timescale 1ns/100ps

module tpu_controller (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              fetch_ins,
    input  logic                              start,
    input  logic        [tpu_pkg::DATA_W-1:0] data,
    input  logic signed [tpu_pkg::DATA_W-1:0] x0_k0,
    input  logic signed [tpu_pkg::DATA_W-1:0] x0_k1,
    input  logic signed [tpu_pkg::DATA_W-1:0] x1_k0,
    input  logic signed [tpu_pkg::DATA_W-1:0] x1_k1,
    output logic                              ins_acc,
    output logic                              ins_relu,
    output logic [tpu_pkg::INS_SHIFT_W-1:0]   ins_shift,
    output logic                              busy,
    output logic                              done,
    output logic                              clear_acc,
    output logic                              capture,
    output logic signed [tpu_pkg::DATA_W-1:0] row0_in,
    output logic signed [tpu_pkg::DATA_W-1:0] row1_in,
    output logic                              load_en
);

    logic [tpu_pkg::DATA_W-1:0] ins;
    logic [2:0]                 cnt;
    logic                       go;

    // start is dropped while a run is in flight
    assign go = start && !busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ins       <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            clear_acc <= 1'b0;
            cnt       <= '0;
        end else begin
            if (fetch_ins && !busy) begin
                ins <= data;
            end
            // clear is a single cycle, ahead of the first feed
            clear_acc <= go && !ins[tpu_pkg::INS_ACC_BIT];
            if (go) begin
                busy <= 1'b1;
                done <= 1'b0;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == 3'(tpu_pkg::COMPUTE_CYCLES)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // instruction fields
    assign ins_acc   = ins[tpu_pkg::INS_ACC_BIT];
    assign ins_relu  = ins[tpu_pkg::INS_RELU_BIT];
    assign ins_shift = ins[tpu_pkg::INS_SHIFT_LSB +: tpu_pkg::INS_SHIFT_W];

    // bottom sums line up on the last busy cycle
    assign capture = busy && (cnt == 3'(tpu_pkg::COMPUTE_CYCLES));

    // k = 0 row fed on cycles 1 and 2, k = 1 row one cycle later
    always_comb begin
        row0_in = '0;
        row1_in = '0;
        if (busy) begin
            case (cnt)
                3'd1: row0_in = x0_k0;
                3'd2: begin
                    row0_in = x1_k0;
                    row1_in = x0_k1;
                end
                3'd3: row1_in = x1_k1;
                default: ;
            endcase
        end
    end

    // operand buffers frozen during a run
    assign load_en = !busy;

endmodule

// ==== tpu_operand_buffer.sv ====
`timescale 1ns/100ps

module tpu_operand_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wr,
    input  logic        [tpu_pkg::DATA_W-1:0] data,
    output logic signed [tpu_pkg::DATA_W-1:0] e0,
    output logic signed [tpu_pkg::DATA_W-1:0] e1,
    output logic signed [tpu_pkg::DATA_W-1:0] e2,
    output logic signed [tpu_pkg::DATA_W-1:0] e3
);

    localparam int IDX_W = $clog2(tpu_pkg::BUF_DEPTH);

    logic signed [tpu_pkg::DATA_W-1:0] entry [tpu_pkg::BUF_DEPTH];
    logic        [IDX_W-1:0]           wr_idx;

    // sequential fill, index wraps after the last entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_idx <= '0;
            for (int i = 0; i < tpu_pkg::BUF_DEPTH; i++) begin
                entry[i] <= '0;
            end
        end else if (wr) begin
            entry[wr_idx] <= data;
            wr_idx        <= wr_idx + 1'b1;
        end
    end

    // flat taps in write order
    assign e0 = entry[0];
    assign e1 = entry[1];
    assign e2 = entry[2];
    assign e3 = entry[3];

endmodule

// ==== tpu_cmd_decoder.sv ====
`timescale 1ns/100ps

module tpu_cmd_decoder (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] cmd,
    input  logic [7:0] din,
    output logic       fetch_w,
    output logic       fetch_inp,
    output logic       fetch_ins,
    output logic       start,
    output logic       read,
    output logic [7:0] data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH_W,
        S_FETCH_INP,
        S_FETCH_INS,
        S_START,
        S_READ
    } state_t;

    state_t state;
    state_t target;
    logic   armed;
    logic   accept;

    // fetch state that matches the command on the pins
    always_comb begin
        case (tpu_pkg::cmd_t'(cmd))
            tpu_pkg::LOAD_W:   target = S_FETCH_W;
            tpu_pkg::LOAD_IN:  target = S_FETCH_INP;
            tpu_pkg::LOAD_INS: target = S_FETCH_INS;
            tpu_pkg::START:    target = S_START;
            tpu_pkg::READ:     target = S_READ;
            // NOP and the two spare codes
            default:           target = S_IDLE;
        endcase
    end

    // only from idle, and only once per NOP gap
    assign accept = (state == S_IDLE) && armed && (target != S_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            armed <= 1'b0;
            data  <= '0;
        end else begin
            // each fetch state lasts a single cycle
            state <= accept ? target : S_IDLE;
            // a held code can not fire twice
            if (target == S_IDLE) begin
                armed <= 1'b1;
            end else if (accept) begin
                armed <= 1'b0;
            end
            // byte captured on the accepting edge
            if (accept) begin
                data <= din;
            end
        end
    end

    // one strobe per fetch state
    assign fetch_w   = (state == S_FETCH_W);
    assign fetch_inp = (state == S_FETCH_INP);
    assign fetch_ins = (state == S_FETCH_INS);
    assign start     = (state == S_START);
    assign read      = (state == S_READ);

endmodule

// ==== tpu_pkg.sv ====
package tpu_pkg;

    // host command codes on uio_in[7:5]
    // codes 6 and 7 are treated like NOP
    typedef enum logic [2:0] {
        NOP      = 3'd0,
        LOAD_W   = 3'd1,
        LOAD_IN  = 3'd2,
        LOAD_INS = 3'd3,
        START    = 3'd4,
        READ     = 3'd5
    } cmd_t;

    // operand byte width
    localparam int DATA_W = 8;

    // array is 2x2, skew and sequencing are written for this size
    localparam int ARRAY_N = 2;

    // entries per operand buffer
    localparam int BUF_DEPTH = ARRAY_N * ARRAY_N;

    // instruction byte fields
    // acc bit adds the new product onto the held results
    localparam int INS_ACC_BIT   = 7;
    // relu bit clamps negative results to zero
    localparam int INS_RELU_BIT  = 6;
    // arithmetic right shift amount
    localparam int INS_SHIFT_LSB = 0;
    localparam int INS_SHIFT_W   = 4;

    // cycles from start strobe to done
    localparam int COMPUTE_CYCLES = 5;

endpackage
